// ==== filelist.f ====
hw/periph_pkg.sv
hw/bus_decoder.sv
hw/sys_ctrl.sv
hw/gpio_ctrl.sv
hw/seg_display.sv
hw/periph_subsys_top.sv
testbench/tb_periph_subsys.sv

// ==== hw/bus_decoder.sv ====
// Host request decoder
`timescale 1ns/1ps
`default_nettype none

module bus_decoder (
   input  wire logic                           i_clk,
   input  wire logic                           i_arst_n,
   input  wire logic                           i_req_stb,
   input  wire periph_pkg::host_req_t          i_req,
   input  wire logic [periph_pkg::DATA_W-1:0]  i_sys_rdata,
   input  wire logic [periph_pkg::DATA_W-1:0]  i_gpio_rdata,
   output logic                                o_sys_stb,
   output logic                                o_gpio_stb,
   output periph_pkg::dev_req_t                o_dev_req,
   output logic                                o_rsp_vld,
   output periph_pkg::host_rsp_t               o_rsp
);
   import periph_pkg::*;

   logic [DEV_W-1:0] dev;
   logic             unmapped;
   logic             rsp_vld_q;
   logic [DEV_W-1:0] dev_q;
   logic             unmapped_q;

   //*********************************************************************
   // request side in the same cycle as the host strobe
   //*********************************************************************
   assign dev        = i_req.addr[DEV_MSB:DEV_LSB];
   assign o_sys_stb  = i_req_stb && (dev == DEV_SYS);
   assign o_gpio_stb = i_req_stb && (dev == DEV_GPIO);
   assign unmapped   = i_req_stb && !o_sys_stb && !o_gpio_stb;

   // word access only so the byte offset and device field drop out
   assign o_dev_req.we    = i_req.we;
   assign o_dev_req.idx   = i_req.addr[REG_MSB:REG_LSB];
   assign o_dev_req.wdata = i_req.wdata;

   //*********************************************************************
   // response side one cycle later
   //*********************************************************************
   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         rsp_vld_q  <= 1'b0;
         dev_q      <= '0;
         unmapped_q <= 1'b0;
      end else begin
         rsp_vld_q  <= i_req_stb;
         unmapped_q <= unmapped;
         if (i_req_stb) begin
            dev_q <= dev;
         end
      end
   end

   always_comb begin
      o_rsp.err = unmapped_q;
      case (dev_q)
         DEV_SYS:  o_rsp.rdata = i_sys_rdata;
         DEV_GPIO: o_rsp.rdata = i_gpio_rdata;
         default:  o_rsp.rdata = '0;
      endcase
   end

   assign o_rsp_vld = rsp_vld_q;

   // error responses are valid and carry no data
   a_err_no_data : assert property (
      @(posedge i_clk) disable iff (!i_arst_n)
      o_rsp.err |-> o_rsp_vld && (o_rsp.rdata == '0)
   );

endmodule

`default_nettype wire

// ==== hw/gpio_ctrl.sv ====
// GPIO controller
`timescale 1ns/1ps
`default_nettype none

module gpio_ctrl (
   input  wire logic                           i_clk,
   input  wire logic                           i_arst_n,
   input  wire logic                           i_stb,
   input  wire periph_pkg::dev_req_t           i_req,
   input  wire logic [periph_pkg::GPIO_W-1:0]  i_gpio,
   output logic [periph_pkg::DATA_W-1:0]       o_rdata,
   output logic [periph_pkg::GPIO_W-1:0]       o_gpio_out,
   output logic [periph_pkg::GPIO_W-1:0]       o_gpio_oe,
   output logic                                o_gpio_irq
);
   import periph_pkg::*;

   logic              wr_en;
   logic [GPIO_W-1:0] meta_q;
   logic [GPIO_W-1:0] sync_q;
   logic [GPIO_W-1:0] prev_q;
   logic [GPIO_W-1:0] rise;
   logic [GPIO_W-1:0] clr;
   logic [GPIO_W-1:0] out_q;
   logic [GPIO_W-1:0] oe_q;
   logic [GPIO_W-1:0] mask_q;
   logic [GPIO_W-1:0] status_q;
   logic              irq_q;
   logic [DATA_W-1:0] rdata_d;
   logic [DATA_W-1:0] rdata_q;

   assign wr_en = i_stb && i_req.we;

   //*********************************************************************
   // input synchronizer and edge detect
   //*********************************************************************
   assign rise = sync_q & ~prev_q;
   // write-one-to-clear, a new edge wins
   assign clr  = (wr_en && (i_req.idx == GPIO_REG_STATUS)) ? i_req.wdata : '0;

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         meta_q   <= '0;
         sync_q   <= '0;
         prev_q   <= '0;
         status_q <= '0;
         irq_q    <= 1'b0;
      end else begin
         meta_q   <= i_gpio;
         sync_q   <= meta_q;
         prev_q   <= sync_q;
         status_q <= (status_q & ~clr) | rise;
         irq_q    <= |(status_q & mask_q);
      end
   end

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         out_q  <= '0;
         oe_q   <= '0;
         mask_q <= '0;
      end else if (wr_en) begin
         case (i_req.idx)
            GPIO_REG_OUT:  out_q  <= i_req.wdata;
            GPIO_REG_OE:   oe_q   <= i_req.wdata;
            GPIO_REG_MASK: mask_q <= i_req.wdata;
            default: ;
         endcase
      end
   end

   always_comb begin
      case (i_req.idx)
         GPIO_REG_IN:     rdata_d = sync_q;
         GPIO_REG_OUT:    rdata_d = out_q;
         GPIO_REG_OE:     rdata_d = oe_q;
         GPIO_REG_MASK:   rdata_d = mask_q;
         GPIO_REG_STATUS: rdata_d = status_q;
         default:         rdata_d = '0;
      endcase
   end

   always_ff @(posedge i_clk) begin
      if (i_stb) begin
         rdata_q <= rdata_d;
      end
   end

   assign o_rdata    = rdata_q;
   assign o_gpio_out = out_q;
   assign o_gpio_oe  = oe_q;
   assign o_gpio_irq = irq_q;

endmodule

`default_nettype wire

// ==== hw/periph_pkg.sv ====
// Peripheral subsystem definitions
`default_nettype none

package periph_pkg;

   //*********************************************************************
   // widths and address fields
   //*********************************************************************
   localparam int ADDR_W  = 16;
   localparam int DATA_W  = 32;
   localparam int GPIO_W  = 32;

   localparam int DEV_MSB = 15;
   localparam int DEV_LSB = 12;
   localparam int REG_MSB = 5;
   localparam int REG_LSB = 2;
   localparam int DEV_W   = DEV_MSB - DEV_LSB + 1;
   localparam int REG_W   = REG_MSB - REG_LSB + 1;

   // device codes, all others unmapped
   localparam logic [DEV_W-1:0] DEV_SYS  = DEV_W'(0);
   localparam logic [DEV_W-1:0] DEV_GPIO = DEV_W'(1);

   // system controller registers
   localparam logic [REG_W-1:0] SYS_REG_VERSION  = REG_W'(0);
   localparam logic [REG_W-1:0] SYS_REG_SWIRQ    = REG_W'(1);
   localparam logic [REG_W-1:0] SYS_REG_DISPLAY  = REG_W'(2);
   localparam logic [REG_W-1:0] SYS_REG_MTIME    = REG_W'(3);
   localparam logic [REG_W-1:0] SYS_REG_MTIMECMP = REG_W'(4);

   // gpio registers
   localparam logic [REG_W-1:0] GPIO_REG_IN     = REG_W'(0);
   localparam logic [REG_W-1:0] GPIO_REG_OUT    = REG_W'(1);
   localparam logic [REG_W-1:0] GPIO_REG_OE     = REG_W'(2);
   localparam logic [REG_W-1:0] GPIO_REG_MASK   = REG_W'(3);
   localparam logic [REG_W-1:0] GPIO_REG_STATUS = REG_W'(4);

   localparam logic [DATA_W-1:0] SYS_VERSION = 32'h0001_0300;

   //*********************************************************************
   // bus structs
   //*********************************************************************
   typedef struct packed {
      logic              we;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
   } host_req_t;

   typedef struct packed {
      logic [DATA_W-1:0] rdata;
      logic              err;
   } host_rsp_t;

   typedef struct packed {
      logic              we;
      logic [REG_W-1:0]  idx;
      logic [DATA_W-1:0] wdata;
   } dev_req_t;

   // active-low segments, g down to a
   function automatic logic [6:0] hex_to_seg(input logic [3:0] nib);
      logic [6:0] seg;
      case (nib)
         4'h0: seg = 7'h40;
         4'h1: seg = 7'h79;
         4'h2: seg = 7'h24;
         4'h3: seg = 7'h30;
         4'h4: seg = 7'h19;
         4'h5: seg = 7'h12;
         4'h6: seg = 7'h02;
         4'h7: seg = 7'h78;
         4'h8: seg = 7'h00;
         4'h9: seg = 7'h10;
         4'ha: seg = 7'h08;
         4'hb: seg = 7'h03;
         4'hc: seg = 7'h46;
         4'hd: seg = 7'h21;
         4'he: seg = 7'h06;
         default: seg = 7'h0e;
      endcase
      return seg;
   endfunction

endpackage

`default_nettype wire

// ==== hw/periph_subsys_top.sv ====
// Peripheral subsystem top level
`timescale 1ns/1ps
`default_nettype none

module periph_subsys_top #(
   parameter int REFRESH_DIV = 50000
) (
   input  wire logic                           i_clk,
   input  wire logic                           i_arst_n,
   input  wire logic                           i_req_stb,
   input  wire periph_pkg::host_req_t          i_req,
   input  wire logic [periph_pkg::GPIO_W-1:0]  i_gpio,
   output logic                                o_rsp_vld,
   output periph_pkg::host_rsp_t               o_rsp,
   output logic [periph_pkg::GPIO_W-1:0]       o_gpio_out,
   output logic [periph_pkg::GPIO_W-1:0]       o_gpio_oe,
   output logic                                o_gpio_irq,
   output logic                                o_timer_irq,
   output logic [1:0]                          o_sw_irq,
   output logic [7:0]                          o_an,
   output logic [6:0]                          o_digits
);
   import periph_pkg::*;

   logic              sys_stb;
   logic              gpio_stb;
   dev_req_t          dev_req;
   logic [DATA_W-1:0] sys_rdata;
   logic [DATA_W-1:0] gpio_rdata;
   logic [DATA_W-1:0] display;

   bus_decoder u_decoder (
      .i_clk        (i_clk),
      .i_arst_n     (i_arst_n),
      .i_req_stb    (i_req_stb),
      .i_req        (i_req),
      .i_sys_rdata  (sys_rdata),
      .i_gpio_rdata (gpio_rdata),
      .o_sys_stb    (sys_stb),
      .o_gpio_stb   (gpio_stb),
      .o_dev_req    (dev_req),
      .o_rsp_vld    (o_rsp_vld),
      .o_rsp        (o_rsp)
   );

   sys_ctrl u_sys (
      .i_clk       (i_clk),
      .i_arst_n    (i_arst_n),
      .i_stb       (sys_stb),
      .i_req       (dev_req),
      .o_rdata     (sys_rdata),
      .o_timer_irq (o_timer_irq),
      .o_sw_irq    (o_sw_irq),
      .o_display   (display)
   );

   gpio_ctrl u_gpio (
      .i_clk      (i_clk),
      .i_arst_n   (i_arst_n),
      .i_stb      (gpio_stb),
      .i_req      (dev_req),
      .i_gpio     (i_gpio),
      .o_rdata    (gpio_rdata),
      .o_gpio_out (o_gpio_out),
      .o_gpio_oe  (o_gpio_oe),
      .o_gpio_irq (o_gpio_irq)
   );

   seg_display #(
      .REFRESH_DIV (REFRESH_DIV)
   ) u_display (
      .i_clk    (i_clk),
      .i_arst_n (i_arst_n),
      .i_value  (display),
      .o_an     (o_an),
      .o_digits (o_digits)
   );

endmodule

`default_nettype wire

// ==== hw/seg_display.sv ====
// Seven-segment display scanner
`timescale 1ns/1ps
`default_nettype none

module seg_display #(
   parameter int REFRESH_DIV = 50000
) (
   input  wire logic                           i_clk,
   input  wire logic                           i_arst_n,
   input  wire logic [periph_pkg::DATA_W-1:0]  i_value,
   output logic [7:0]                          o_an,
   output logic [6:0]                          o_digits
);
   import periph_pkg::*;

   localparam int DIV_W = (REFRESH_DIV > 1) ? $clog2(REFRESH_DIV) : 1;

   logic [DIV_W-1:0] div_q;
   logic             step;
   logic [2:0]       digit_q;
   logic [2:0]       digit_nxt;
   logic [7:0]       an_q;
   logic [3:0]       nibble;

   //*********************************************************************
   // refresh divider and digit index
   //*********************************************************************
   assign step      = (div_q == DIV_W'(REFRESH_DIV - 1));
   assign digit_nxt = step ? digit_q + 3'd1 : digit_q;

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         div_q   <= '0;
         digit_q <= '0;
         an_q    <= '1;
      end else begin
         if (step) begin
            div_q <= '0;
         end else begin
            div_q <= div_q + DIV_W'(1);
         end
         digit_q <= digit_nxt;
         // anode tracks the index with one low at a time
         an_q    <= ~(8'b1 << digit_nxt);
      end
   end

   // segments straight from the live value
   assign nibble   = i_value[{digit_q, 2'b00} +: 4];
   assign o_digits = hex_to_seg(nibble);
   assign o_an     = an_q;

   // the low anode is the digit whose nibble is shown
   a_one_anode : assert property (
      @(posedge i_clk) disable iff (!i_arst_n)
      $past(i_arst_n) |-> $onehot(~o_an) && !o_an[digit_q]
   );

endmodule

`default_nettype wire

// ==== hw/sys_ctrl.sv ====
// System controller registers
`timescale 1ns/1ps
`default_nettype none

module sys_ctrl (
   input  wire logic                           i_clk,
   input  wire logic                           i_arst_n,
   input  wire logic                           i_stb,
   input  wire periph_pkg::dev_req_t           i_req,
   output logic [periph_pkg::DATA_W-1:0]       o_rdata,
   output logic                                o_timer_irq,
   output logic [1:0]                          o_sw_irq,
   output logic [periph_pkg::DATA_W-1:0]       o_display
);
   import periph_pkg::*;

   logic              wr_en;
   logic [1:0]        sw_irq_q;
   logic [DATA_W-1:0] display_q;
   logic [DATA_W-1:0] mtime_q;
   logic [DATA_W-1:0] mtimecmp_q;
   logic              timer_irq_q;
   logic [DATA_W-1:0] rdata_d;
   logic [DATA_W-1:0] rdata_q;

   assign wr_en = i_stb && i_req.we;

   //*********************************************************************
   // software writable registers
   //*********************************************************************
   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         sw_irq_q   <= '0;
         display_q  <= '0;
         mtimecmp_q <= '1;
      end else if (wr_en) begin
         // version and mtime are read-only
         case (i_req.idx)
            SYS_REG_SWIRQ:    sw_irq_q   <= i_req.wdata[1:0];
            SYS_REG_DISPLAY:  display_q  <= i_req.wdata;
            SYS_REG_MTIMECMP: mtimecmp_q <= i_req.wdata;
            default: ;
         endcase
      end
   end

   //*********************************************************************
   // free-running timer and compare
   //*********************************************************************
   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         mtime_q     <= '0;
         timer_irq_q <= 1'b0;
      end else begin
         mtime_q     <= mtime_q + DATA_W'(1);
         timer_irq_q <= (mtime_q >= mtimecmp_q);
      end
   end

   // read data sees state from before this access
   always_comb begin
      case (i_req.idx)
         SYS_REG_VERSION:  rdata_d = SYS_VERSION;
         SYS_REG_SWIRQ:    rdata_d = DATA_W'(sw_irq_q);
         SYS_REG_DISPLAY:  rdata_d = display_q;
         SYS_REG_MTIME:    rdata_d = mtime_q;
         SYS_REG_MTIMECMP: rdata_d = mtimecmp_q;
         default:          rdata_d = '0;
      endcase
   end

   always_ff @(posedge i_clk) begin
      if (i_stb) begin
         rdata_q <= rdata_d;
      end
   end

   assign o_rdata     = rdata_q;
   assign o_timer_irq = timer_irq_q;
   assign o_sw_irq    = sw_irq_q;
   assign o_display   = display_q;

   // an all-ones compare only fires once mtime wraps to all ones
   a_cmp_max_quiet : assert property (
      @(posedge i_clk) disable iff (!i_arst_n)
      $rose(o_timer_irq) |-> ($past(mtimecmp_q) != '1) || (&$past(mtime_q))
   );

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the peripheral subsystem simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   -f filelist.f \
   --top-module tb_periph_subsys \
   -o sim_tb
build_status=$?
if [ "$build_status" -ne 0 ]; then
   echo "verilator build failed with status $build_status"
   exit 1
fi

sim_out=$(./obj_dir/sim_tb 2>&1)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if echo "$sim_out" | grep -q "Verification passed"; then
   exit 0
else
   echo "pass message not found in simulation output"
   exit 1
fi

// ==== testbench/tb_periph_subsys.sv ====
// Peripheral subsystem testbench
`timescale 1ns/1ps
`default_nettype none

module tb_periph_subsys;
   import periph_pkg::*;

   // about 600 cycles of tests, limit leaves a wide margin
   localparam int MAX_CYCLES = 4000;

   logic              i_clk;
   logic              i_arst_n;
   logic              i_req_stb;
   host_req_t         i_req;
   logic [GPIO_W-1:0] i_gpio;
   logic              o_rsp_vld;
   host_rsp_t         o_rsp;
   logic [GPIO_W-1:0] o_gpio_out;
   logic [GPIO_W-1:0] o_gpio_oe;
   logic              o_gpio_irq;
   logic              o_timer_irq;
   logic [1:0]        o_sw_irq;
   logic [7:0]        o_an;
   logic [6:0]        o_digits;

   // register model
   logic [1:0]        m_sw;
   logic [DATA_W-1:0] m_display;
   logic [DATA_W-1:0] m_mtimecmp;
   logic [GPIO_W-1:0] m_out;
   logic [GPIO_W-1:0] m_oe;
   logic [GPIO_W-1:0] m_mask;
   logic [GPIO_W-1:0] m_status;
   logic [GPIO_W-1:0] m_meta;
   logic [GPIO_W-1:0] m_sync;
   logic [GPIO_W-1:0] m_prev;
   logic [DATA_W-1:0] last_mtime;

   // request waiting for its response
   logic              pend_vld;
   logic              pend_mtime;
   host_req_t         pend_req;
   host_rsp_t         pend_exp;
   int                cycles;

   periph_subsys_top #(
      .REFRESH_DIV (4)
   ) dut0 (
      .i_clk       (i_clk),
      .i_arst_n    (i_arst_n),
      .i_req_stb   (i_req_stb),
      .i_req       (i_req),
      .i_gpio      (i_gpio),
      .o_rsp_vld   (o_rsp_vld),
      .o_rsp       (o_rsp),
      .o_gpio_out  (o_gpio_out),
      .o_gpio_oe   (o_gpio_oe),
      .o_gpio_irq  (o_gpio_irq),
      .o_timer_irq (o_timer_irq),
      .o_sw_irq    (o_sw_irq),
      .o_an        (o_an),
      .o_digits    (o_digits)
   );

   initial begin
      i_clk = 1'b0;
      forever #20 i_clk = ~i_clk;
   end

   //*********************************************************************
   // failure reporting and compare tasks
   //*********************************************************************
   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Verification failed");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic check_rsp(input string name, input host_rsp_t got, input host_rsp_t exp);
      if (got !== exp) begin
         abort_run($sformatf("CHECK FAILED %s: got rdata=%h err=%h expected rdata=%h err=%h",
                             name, got.rdata, got.err, exp.rdata, exp.err));
      end
   endtask

   task automatic check_word(input string name, input logic [DATA_W-1:0] got,
                             input logic [DATA_W-1:0] exp);
      if (got !== exp) begin
         abort_run($sformatf("CHECK FAILED %s: got %h expected %h", name, got, exp));
      end
   endtask

   task automatic check_irq(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         abort_run($sformatf("CHECK FAILED %s: got %h expected %h", name, got, exp));
      end
   endtask

   // active-low segments, g down to a
   function automatic logic [6:0] seg_pattern(input logic [3:0] nib);
      logic [6:0] table_q [16];
      table_q = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
                  7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e};
      return table_q[nib];
   endfunction

   task automatic check_segments(input logic [7:0] an, input logic [6:0] digits,
                                 input logic [DATA_W-1:0] value);
      int         zeros;
      int         pos;
      int         i;
      logic [6:0] exp;
      zeros = 0;
      pos   = 0;
      for (i = 0; i < 8; i++) begin
         if (!an[i]) begin
            zeros++;
            pos = i;
         end
      end
      if (zeros != 1) begin
         abort_run($sformatf("display drives %0d anodes low instead of one (o_an=%h)",
                             zeros, an));
      end
      exp = seg_pattern(value[pos*4 +: 4]);
      if (digits !== exp) begin
         abort_run($sformatf("CHECK FAILED o_digits: got %h expected %h", digits, exp));
      end
   endtask

   //*********************************************************************
   // model and cycle stepping
   //*********************************************************************
   function automatic host_rsp_t model_read(input logic [DEV_W-1:0] dev,
                                            input logic [REG_W-1:0] idx);
      host_rsp_t r;
      r.rdata = '0;
      r.err   = 1'b0;
      if (dev == DEV_SYS) begin
         case (idx)
            SYS_REG_VERSION:  r.rdata = SYS_VERSION;
            SYS_REG_SWIRQ:    r.rdata = DATA_W'(m_sw);
            SYS_REG_DISPLAY:  r.rdata = m_display;
            SYS_REG_MTIMECMP: r.rdata = m_mtimecmp;
            default:          r.rdata = '0;
         endcase
      end else if (dev == DEV_GPIO) begin
         case (idx)
            GPIO_REG_IN:     r.rdata = m_sync;
            GPIO_REG_OUT:    r.rdata = m_out;
            GPIO_REG_OE:     r.rdata = m_oe;
            GPIO_REG_MASK:   r.rdata = m_mask;
            GPIO_REG_STATUS: r.rdata = m_status;
            default:         r.rdata = '0;
         endcase
      end else begin
         r.err = 1'b1;
      end
      return r;
   endfunction

   function automatic host_req_t make_req(input logic we, input logic [DEV_W-1:0] dev,
                                          input logic [REG_W-1:0] idx,
                                          input logic [DATA_W-1:0] wdata);
      host_req_t r;
      r.we    = we;
      // unused address bits carry noise
      r.addr  = {dev, 6'($urandom), idx, 2'($urandom)};
      r.wdata = wdata;
      return r;
   endfunction

   function automatic host_req_t random_req();
      int               pick;
      logic [DEV_W-1:0] dev;
      pick = int'($urandom % 10);
      if (pick < 4) begin
         dev = DEV_SYS;
      end else if (pick < 8) begin
         dev = DEV_GPIO;
      end else begin
         dev = DEV_W'(2 + $urandom % 14);
      end
      return make_req(1'($urandom), dev, REG_W'($urandom % 8), $urandom);
   endfunction

   task automatic issue(input host_req_t req);
      i_req_stb  = 1'b1;
      i_req      = req;
      pend_vld   = 1'b1;
      pend_req   = req;
      pend_mtime = (req.addr[DEV_MSB:DEV_LSB] == DEV_SYS) &&
                   (req.addr[REG_MSB:REG_LSB] == SYS_REG_MTIME);
      pend_exp   = model_read(req.addr[DEV_MSB:DEV_LSB], req.addr[REG_MSB:REG_LSB]);
   endtask

   // one clock, checks everything that is due after this edge
   task automatic step_cycle();
      logic [DEV_W-1:0]  dev;
      logic [REG_W-1:0]  idx;
      logic [GPIO_W-1:0] rise;
      logic [GPIO_W-1:0] clr;
      logic              irq_exp;
      @(posedge i_clk);
      #2;
      cycles++;
      if (cycles > MAX_CYCLES) begin
         abort_run("timeout, the run went past its cycle limit");
      end
      dev     = pend_req.addr[DEV_MSB:DEV_LSB];
      idx     = pend_req.addr[REG_MSB:REG_LSB];
      irq_exp = |(m_status & m_mask);
      rise    = m_sync & ~m_prev;
      clr     = '0;
      check_irq("o_rsp_vld", o_rsp_vld, pend_vld);
      if (pend_vld) begin
         if (pend_mtime) begin
            check_irq("o_rsp.err", o_rsp.err, 1'b0);
            if (o_rsp.rdata <= last_mtime) begin
               abort_run($sformatf("mtime read %h did not increase past %h",
                                   o_rsp.rdata, last_mtime));
            end
            last_mtime = o_rsp.rdata;
         end else begin
            check_rsp("o_rsp", o_rsp, pend_exp);
         end
         if (pend_req.we && dev == DEV_SYS) begin
            case (idx)
               SYS_REG_SWIRQ:    m_sw       = pend_req.wdata[1:0];
               SYS_REG_DISPLAY:  m_display  = pend_req.wdata;
               SYS_REG_MTIMECMP: m_mtimecmp = pend_req.wdata;
               default: ;
            endcase
         end else if (pend_req.we && dev == DEV_GPIO) begin
            case (idx)
               GPIO_REG_OUT:    m_out  = pend_req.wdata;
               GPIO_REG_OE:     m_oe   = pend_req.wdata;
               GPIO_REG_MASK:   m_mask = pend_req.wdata;
               GPIO_REG_STATUS: clr    = pend_req.wdata;
               default: ;
            endcase
         end
      end
      // sticky edges, a new edge beats the clear
      m_status = (m_status & ~clr) | rise;
      m_prev   = m_sync;
      m_sync   = m_meta;
      m_meta   = i_gpio;
      check_irq("o_gpio_irq", o_gpio_irq, irq_exp);
      check_word("o_gpio_out", o_gpio_out, m_out);
      check_word("o_gpio_oe", o_gpio_oe, m_oe);
      check_word("o_sw_irq", DATA_W'(o_sw_irq), DATA_W'(m_sw));
      check_segments(o_an, o_digits, m_display);
      pend_vld  = 1'b0;
      i_req_stb = 1'b0;
   endtask

   task automatic wait_timer(input logic level);
      int n;
      n = 0;
      while (o_timer_irq !== level && n < 2) begin
         step_cycle();
         n++;
      end
      check_irq("o_timer_irq", o_timer_irq, level);
   endtask

   //*********************************************************************
   // test sequence
   //*********************************************************************
   initial begin
      int n;
      void'($urandom(53329));
      i_arst_n   = 1'b0;
      i_req_stb  = 1'b0;
      i_req      = '0;
      i_gpio     = '0;
      m_sw       = '0;
      m_display  = '0;
      m_mtimecmp = '1;
      m_out      = '0;
      m_oe       = '0;
      m_mask     = '0;
      m_status   = '0;
      m_meta     = '0;
      m_sync     = '0;
      m_prev     = '0;
      last_mtime = '0;
      pend_vld   = 1'b0;
      pend_mtime = 1'b0;
      pend_req   = '0;
      pend_exp   = '0;
      cycles     = 0;
      repeat (8) @(posedge i_clk);
      #2;
      check_irq("o_rsp_vld", o_rsp_vld, 1'b0);
      check_irq("o_timer_irq", o_timer_irq, 1'b0);
      check_irq("o_gpio_irq", o_gpio_irq, 1'b0);
      check_word("o_sw_irq", DATA_W'(o_sw_irq), '0);
      check_word("o_gpio_out", o_gpio_out, '0);
      check_word("o_gpio_oe", o_gpio_oe, '0);
      check_word("o_an", DATA_W'(o_an), 32'h0000_00ff);
      i_arst_n = 1'b1;
      step_cycle();

      // random accesses, mostly back to back
      for (n = 0; n < 400; n++) begin
         if ($urandom % 8 == 0) begin
            step_cycle();
         end
         if ($urandom % 10 == 0) begin
            i_gpio = $urandom;
         end
         issue(random_req());
         step_cycle();
      end

      // timer reads and compare interrupt
      for (n = 0; n < 4; n++) begin
         issue(make_req(1'b0, DEV_SYS, SYS_REG_MTIME, '0));
         step_cycle();
      end
      issue(make_req(1'b1, DEV_SYS, SYS_REG_MTIMECMP, '0));
      step_cycle();
      wait_timer(1'b1);
      issue(make_req(1'b1, DEV_SYS, SYS_REG_MTIMECMP, '1));
      step_cycle();
      wait_timer(1'b0);
      issue(make_req(1'b0, DEV_SYS, SYS_REG_MTIMECMP, '0));
      step_cycle();

      // gpio input, edges and write-one-to-clear
      issue(make_req(1'b1, DEV_GPIO, GPIO_REG_MASK, $urandom));
      step_cycle();
      for (n = 0; n < 8; n++) begin
         i_gpio = '0;
         repeat (3) step_cycle();
         issue(make_req(1'b1, DEV_GPIO, GPIO_REG_STATUS, '1));
         step_cycle();
         issue(make_req(1'b0, DEV_GPIO, GPIO_REG_STATUS, '0));
         step_cycle();
         i_gpio = $urandom;
         repeat (3) step_cycle();
         issue(make_req(1'b0, DEV_GPIO, GPIO_REG_IN, '0));
         step_cycle();
         issue(make_req(1'b0, DEV_GPIO, GPIO_REG_STATUS, '0));
         step_cycle();
         repeat (2) step_cycle();
         issue(make_req(1'b1, DEV_GPIO, GPIO_REG_STATUS, '1));
         step_cycle();
         issue(make_req(1'b0, DEV_GPIO, GPIO_REG_STATUS, '0));
         step_cycle();
         step_cycle();
      end

      $display("Verification passed");
      $finish;
   end

endmodule

`default_nettype wire
